//--- testbench/fetch_patterns.txt
// op[63:60] 1 tlb: idx[58:56] v/p/x[54:52] vpn[47:28] ppn[7:0], 2 redirect: {init,rs,bp}[58:56] addr[31:0]
// 3 take: bank[56] count[15:0], 4 exception: bank[56] {miss,prot}[1:0], 5 fill delay[15:0], 0 end
1_0_7_0_00010_00000_11  // code page
1_1_7_0_00011_00000_22  // resteer target page
1_2_7_0_00012_00000_33  // bp target page
1_3_6_0_00020_00000_44  // data page, no execute
5_0_0000000000_0003
2_4_000000_00010040     // init on an even line
3_0_0000000000_0004
3_1_0000000000_0004
2_4_000000_00010050     // init on an odd line, lines hit again
3_0_0000000000_0002
3_1_0000000000_0002
5_0_0000000000_0014     // slow fills
2_7_000000_00010000     // init, resteer and bp together
3_0_0000000000_0003
3_1_0000000000_0003
2_3_000000_00010000     // resteer and bp
3_0_0000000000_0002
3_1_0000000000_0002
2_1_000000_00010000     // bp alone
3_0_0000000000_0001
3_1_0000000000_0001
2_4_000000_00030000     // unmapped page
4_0_0000000000000_2
4_1_0000000000000_2
2_4_000000_00020000     // no execute right
4_0_0000000000000_1
4_1_0000000000000_1
0000000000000000

//--- compile.f
+incdir+hdl
hdl/fetch_addr_pkg.sv
hdl/fetch_mem_pkg.sv
hdl/fetch_addr_select.sv
hdl/fetch_tlb.sv
hdl/icache_bank.sv
hdl/fetch_top.sv
testbench/tb_clock_gen.sv
testbench/tb_fetch_top.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fetch_addr_pkg.sv
      - hdl/fetch_mem_pkg.sv
      - hdl/fetch_addr_select.sv
      - hdl/fetch_tlb.sv
      - hdl/icache_bank.sv
      - hdl/fetch_top.sv

  - target: any(test, simulation)
    include_dirs:
      - hdl
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_fetch_top.sv

//--- testbench/tb_fetch_top.sv
`default_nettype none
`include "fetch_defines.svh"

module tb_fetch_top;

    localparam int MAX_CMDS = 64;
    localparam int ST_OK    = 0;
    localparam int ST_MISS  = 1;
    localparam int ST_PROT  = 2;

    logic                          clk;
    logic                          rst_n;
    fetch_addr_pkg::redirect_t     redirect;
    fetch_mem_pkg::tlb_load_t      tlb_load;
    logic                          take        [2];
    fetch_mem_pkg::fill_rsp_t      fill_rsp    [2];
    logic                          fill_credit [2];
    fetch_mem_pkg::fetch_out_t     fetch_out   [2];
    fetch_mem_pkg::fill_req_t      fill_req    [2];

    logic [63:0]                   patterns [MAX_CMDS];
    fetch_mem_pkg::tlb_entry_t     model_tlb [`FETCH_TLB_ENTRIES];
    fetch_addr_pkg::vline_t        exp_line  [2];   // expected pointer per bank
    int                            req_cnt    [2];
    int                            rsp_cnt    [2];
    int                            credit_cnt [2];
    int                            max_delay   = 0;
    int                            checks      = 0;
    int                            value_errors = 0;
    int                            other_errors = 0;
    int                            cycle_cnt   = 0;
    int                            cycle_limit = 0;
    string                         test_name   = "setup";

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    fetch_top i_fetch_top (
        .clk_i              (clk),
        .rst_n_i            (rst_n),
        .redirect_i         (redirect),
        .tlb_load_i         (tlb_load),
        .take_even_i        (take[0]),
        .take_odd_i         (take[1]),
        .fill_rsp_even_i    (fill_rsp[0]),
        .fill_rsp_odd_i     (fill_rsp[1]),
        .fill_credit_even_i (fill_credit[0]),
        .fill_credit_odd_i  (fill_credit[1]),
        .fetch_even_o       (fetch_out[0]),
        .fetch_odd_o        (fetch_out[1]),
        .fill_req_even_o    (fill_req[0]),
        .fill_req_odd_o     (fill_req[1])
    );

    //////////////////////////////
    // reference rules
    //////////////////////////////

    // word i of a line holds the physical line address and i
    function automatic fetch_mem_pkg::line_t line_data(input fetch_mem_pkg::pline_t pl);
        fetch_mem_pkg::line_t d;
        for (int i = 0; i < $bits(fetch_mem_pkg::line_t) / 32; i++) begin
            d[i*32 +: 32] = {pl, 16'(i)};
        end
        return d;
    endfunction

    function automatic int lookup_tlb(input fetch_addr_pkg::vline_t vl,
                                      output fetch_mem_pkg::ppn_t ppn);
        int status;
        status = ST_MISS;
        ppn    = '0;
        for (int i = 0; i < `FETCH_TLB_ENTRIES; i++) begin
            if (model_tlb[i].valid && model_tlb[i].present && model_tlb[i].vpn == vl[27:8]) begin
                ppn    = model_tlb[i].ppn;
                status = model_tlb[i].executable ? ST_OK : ST_PROT;
            end
        end
        return status;
    endfunction

    task automatic report_mismatch(input string what, input logic [127:0] exp,
                                   input logic [127:0] act);
        value_errors++;
        $display("error %s: %s expected %h actual %h", test_name, what, exp, act);
    endtask

    //////////////////////////////
    // stimulus tasks
    //////////////////////////////

    task automatic load_tlb_entry(input logic [2:0] idx, input fetch_mem_pkg::tlb_entry_t e);
        fetch_mem_pkg::tlb_load_t ld;
        ld.en    = 1'b1;
        ld.idx   = idx;
        ld.entry = e;
        @(posedge clk);
        tlb_load <= ld;
        @(posedge clk);
        tlb_load <= '0;
        model_tlb[idx] = e;
    endtask

    // sources {init, resteer, bp}: init at base, resteer one page up, bp two pages up
    task automatic apply_redirect(input logic [2:0] srcs, input fetch_addr_pkg::vaddr_t base);
        fetch_addr_pkg::redirect_t r;
        fetch_addr_pkg::vaddr_t    addr;
        fetch_addr_pkg::vline_t    init_l;
        fetch_addr_pkg::vline_t    rs_l;
        fetch_addr_pkg::vline_t    bp_l;
        init_l = base[31:4];
        addr   = base + 32'h0000_1000;
        rs_l   = addr[31:4];
        rs_l[0] = 1'b0;
        addr   = base + 32'h0000_2000;
        bp_l   = addr[31:4];
        bp_l[0] = 1'b0;
        r = '0;
        r.init_valid    = srcs[2];
        r.init_addr     = base;
        r.resteer_valid = srcs[1];
        r.resteer_even  = rs_l;
        r.resteer_odd   = rs_l | 28'd1;
        r.bp_valid      = srcs[0];
        r.bp_even       = bp_l;
        r.bp_odd        = bp_l | 28'd1;
        if (srcs[2]) begin
            exp_line[0] = init_l[0] ? init_l + 28'd1 : init_l;
            exp_line[1] = init_l[0] ? init_l : init_l + 28'd1;
        end else if (srcs[1]) begin
            exp_line[0] = r.resteer_even;
            exp_line[1] = r.resteer_odd;
        end else if (srcs[0]) begin
            exp_line[0] = r.bp_even;
            exp_line[1] = r.bp_odd;
        end
        @(posedge clk);
        redirect <= r;
        @(posedge clk);
        redirect <= '0;
    endtask

    task automatic take_lines(input int bank, input int count);
        fetch_mem_pkg::fetch_out_t f;
        fetch_mem_pkg::ppn_t       ppn;
        fetch_mem_pkg::pline_t     pl;
        int                        status;
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
            while (!fetch_out[bank].valid) begin
                @(negedge clk);
            end
            f      = fetch_out[bank];
            status = lookup_tlb(exp_line[bank], ppn);
            pl     = {ppn, exp_line[bank][7:0]};
            checks++;
            if (status != ST_OK) begin
                other_errors++;
                $display("%s: line %h has no executable mapping", test_name, exp_line[bank]);
            end
            if (f.vline != exp_line[bank]) begin
                report_mismatch("line address", exp_line[bank], f.vline);
            end
            if ({f.tlb_miss, f.prot_fault} != 2'b00) begin
                report_mismatch("exception flags", 2'b00, {f.tlb_miss, f.prot_fault});
            end
            if (f.data != line_data(pl)) begin
                report_mismatch("line data", line_data(pl), f.data);
            end
            @(posedge clk);
            take[bank] <= 1'b1;
            @(posedge clk);
            take[bank] <= 1'b0;
            exp_line[bank] = exp_line[bank] + 28'd2;
        end
    endtask

    task automatic expect_exception(input int bank, input logic [1:0] flags);
        fetch_mem_pkg::fetch_out_t f;
        fetch_mem_pkg::ppn_t       ppn;
        int                        status;
        int                        reqs_before;
        logic [1:0]                exp_flags;
        status    = lookup_tlb(exp_line[bank], ppn);
        exp_flags = {status == ST_MISS, status == ST_PROT};
        if (exp_flags != flags) begin
            other_errors++;
            $display("%s: pattern flags %b disagree with the loaded TLB", test_name, flags);
        end
        @(negedge clk);
        while (!fetch_out[bank].valid) begin
            @(negedge clk);
        end
        f           = fetch_out[bank];
        reqs_before = req_cnt[bank];
        checks++;
        if (f.vline != exp_line[bank]) begin
            report_mismatch("line address", exp_line[bank], f.vline);
        end
        if ({f.tlb_miss, f.prot_fault} != exp_flags) begin
            report_mismatch("exception flags", exp_flags, {f.tlb_miss, f.prot_fault});
        end
        if (f.data != '0) begin
            report_mismatch("line data", '0, f.data);
        end
        repeat (4) @(negedge clk);
        if (req_cnt[bank] != reqs_before) begin
            other_errors++;
            $display("%s: a fill was requested for a faulting line", test_name);
        end
    endtask

    //////////////////////////////
    // fill memory
    //////////////////////////////

    task automatic serve_fills(input int bank);
        fetch_mem_pkg::fill_rsp_t rsp;
        int                       delay;
        forever begin
            @(negedge clk);
            if (fill_req[bank].valid) begin
                rsp.valid = 1'b1;
                rsp.pline = fill_req[bank].pline;
                rsp.data  = line_data(fill_req[bank].pline);
                delay     = $urandom % (max_delay + 1);
                repeat (delay) @(posedge clk);
                @(posedge clk);
                fill_rsp[bank] <= rsp;
                @(posedge clk);
                fill_rsp[bank]    <= '0;
                fill_credit[bank] <= 1'b1;   // credit one cycle after the response
                @(posedge clk);
                fill_credit[bank] <= 1'b0;
            end
        end
    endtask

    // counts from values sampled at the edge, credits before requests
    always @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (rst_n) begin
                if (fill_credit[b]) credit_cnt[b]++;
                if (fill_rsp[b].valid) rsp_cnt[b]++;
                if (fill_req[b].valid) begin
                    req_cnt[b]++;
                    if (req_cnt[b] - credit_cnt[b] > `FETCH_FILL_CREDITS) begin
                        other_errors++;
                        $display("bank %0d has more fills outstanding than credits", b);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles in %s", cycle_cnt, test_name);
            $display("=== FAIL ===");
            $finish;
        end
    end

    //////////////////////////////
    // command sequence
    //////////////////////////////

    initial begin
        logic [63:0]               cmd;
        fetch_mem_pkg::tlb_entry_t e;
        int                        n_cmds;
        redirect       = '0;
        tlb_load       = '0;
        for (int b = 0; b < 2; b++) begin
            take[b]        = 1'b0;
            fill_rsp[b]    = '0;
            fill_credit[b] = 1'b0;
            exp_line[b]    = '0;
            req_cnt[b]     = 0;
            rsp_cnt[b]     = 0;
            credit_cnt[b]  = 0;
        end
        for (int i = 0; i < `FETCH_TLB_ENTRIES; i++) begin
            model_tlb[i] = '0;
        end
        for (int i = 0; i < MAX_CMDS; i++) begin
            patterns[i] = '0;   // opcode 0 ends the list
        end
        void'($urandom(32'hb973b534));
        $readmemh("testbench/fetch_patterns.txt", patterns);
        n_cmds = 0;
        while (n_cmds < MAX_CMDS && patterns[n_cmds][63:60] != 4'h0) begin
            n_cmds++;
        end
        if (n_cmds == 0) begin
            other_errors++;
            $display("pattern file holds no commands");
        end
        cycle_limit = 200 * (n_cmds + 1);
        fork
            serve_fills(0);
            serve_fills(1);
        join_none
        wait (rst_n);
        for (int c = 0; c < n_cmds; c++) begin
            cmd = patterns[c];
            case (cmd[63:60])
                4'h1: begin
                    test_name    = $sformatf("tlb load %0d", cmd[58:56]);
                    e.valid      = cmd[54];
                    e.present    = cmd[53];
                    e.executable = cmd[52];
                    e.vpn        = cmd[47:28];
                    e.ppn        = cmd[7:0];
                    load_tlb_entry(cmd[58:56], e);
                end
                4'h2: begin
                    test_name = $sformatf("redirect %b to %h", cmd[58:56], cmd[31:0]);
                    apply_redirect(cmd[58:56], cmd[31:0]);
                end
                4'h3: begin
                    test_name = $sformatf("take bank %0d at %h", cmd[56], exp_line[cmd[56]]);
                    take_lines(cmd[56], cmd[15:0]);
                end
                4'h4: begin
                    test_name = $sformatf("exception bank %0d", cmd[56]);
                    expect_exception(cmd[56], cmd[1:0]);
                end
                4'h5: max_delay = cmd[15:0];
                default: begin
                    other_errors++;
                    $display("unknown command %h at entry %0d", cmd, c);
                end
            endcase
        end
        // let the last fills and credits come back
        test_name = "drain";
        while (credit_cnt[0] != req_cnt[0] || credit_cnt[1] != req_cnt[1]) begin
            @(negedge clk);
        end
        for (int b = 0; b < 2; b++) begin
            if (rsp_cnt[b] != req_cnt[b]) begin
                report_mismatch("fill responses", req_cnt[b], rsp_cnt[b]);
            end
        end
        $display("checks %0d, value errors %0d, other errors %0d, fills %0d/%0d",
                 checks, value_errors, other_errors, req_cnt[0], req_cnt[1]);
        if (value_errors == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;   // period 10
    end

    // reset held low over the first 5 rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

`default_nettype wire

//--- hdl/fetch_top.sv
`default_nettype none

module fetch_top (
    input  wire logic                       clk_i,
    input  wire logic                       rst_n_i,
    input  wire fetch_addr_pkg::redirect_t  redirect_i,
    input  wire fetch_mem_pkg::tlb_load_t   tlb_load_i,
    input  wire logic                       take_even_i,
    input  wire logic                       take_odd_i,
    input  wire fetch_mem_pkg::fill_rsp_t   fill_rsp_even_i,
    input  wire fetch_mem_pkg::fill_rsp_t   fill_rsp_odd_i,
    input  wire logic                       fill_credit_even_i,
    input  wire logic                       fill_credit_odd_i,
    output fetch_mem_pkg::fetch_out_t       fetch_even_o,
    output fetch_mem_pkg::fetch_out_t       fetch_odd_o,
    output fetch_mem_pkg::fill_req_t        fill_req_even_o,
    output fetch_mem_pkg::fill_req_t        fill_req_odd_o
);

    fetch_addr_pkg::vline_t line_even;
    fetch_addr_pkg::vline_t line_odd;
    fetch_mem_pkg::ppn_t    ppn_even;
    fetch_mem_pkg::ppn_t    ppn_odd;
    logic                   started_even;
    logic                   started_odd;
    logic                   consumed_even;
    logic                   consumed_odd;
    logic                   tlb_miss_even;
    logic                   tlb_miss_odd;
    logic                   prot_even;
    logic                   prot_odd;

    //////////////////////////////
    // even bank
    //////////////////////////////

    fetch_addr_select #(.PARITY(0)) u_sel_even (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect_i),
        .consumed_i   (consumed_even),
        .fetch_line_o (line_even),
        .started_o    (started_even)
    );

    fetch_tlb u_tlb_even (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .tlb_load_i    (tlb_load_i),    // both TLBs see every load
        .lookup_line_i (line_even),
        .ppn_o         (ppn_even),
        .miss_o        (tlb_miss_even),
        .prot_fault_o  (prot_even)
    );

    icache_bank u_bank_even (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .active_i      (started_even),
        .fetch_line_i  (line_even),
        .ppn_i         (ppn_even),
        .tlb_miss_i    (tlb_miss_even),
        .prot_fault_i  (prot_even),
        .take_i        (take_even_i),
        .fill_rsp_i    (fill_rsp_even_i),
        .fill_credit_i (fill_credit_even_i),
        .fill_req_o    (fill_req_even_o),
        .fetch_o       (fetch_even_o),
        .consumed_o    (consumed_even)
    );

    //////////////////////////////
    // odd bank
    //////////////////////////////

    fetch_addr_select #(.PARITY(1)) u_sel_odd (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .redirect_i   (redirect_i),
        .consumed_i   (consumed_odd),
        .fetch_line_o (line_odd),
        .started_o    (started_odd)
    );

    fetch_tlb u_tlb_odd (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .tlb_load_i    (tlb_load_i),
        .lookup_line_i (line_odd),
        .ppn_o         (ppn_odd),
        .miss_o        (tlb_miss_odd),
        .prot_fault_o  (prot_odd)
    );

    icache_bank u_bank_odd (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .active_i      (started_odd),
        .fetch_line_i  (line_odd),
        .ppn_i         (ppn_odd),
        .tlb_miss_i    (tlb_miss_odd),
        .prot_fault_i  (prot_odd),
        .take_i        (take_odd_i),
        .fill_rsp_i    (fill_rsp_odd_i),
        .fill_credit_i (fill_credit_odd_i),
        .fill_req_o    (fill_req_odd_o),
        .fetch_o       (fetch_odd_o),
        .consumed_o    (consumed_odd)
    );

endmodule

`default_nettype wire

//--- hdl/icache_bank.sv
`default_nettype none
`include "fetch_defines.svh"

module icache_bank (
    input  wire logic                       clk_i,
    input  wire logic                       rst_n_i,
    input  wire logic                       active_i,
    input  wire fetch_addr_pkg::vline_t     fetch_line_i,
    input  wire fetch_mem_pkg::ppn_t        ppn_i,
    input  wire logic                       tlb_miss_i,
    input  wire logic                       prot_fault_i,
    input  wire logic                       take_i,
    input  wire fetch_mem_pkg::fill_rsp_t   fill_rsp_i,
    input  wire logic                       fill_credit_i,
    output fetch_mem_pkg::fill_req_t        fill_req_o,
    output fetch_mem_pkg::fetch_out_t       fetch_o,
    output logic                            consumed_o
);

    localparam int PLINE_W = $bits(fetch_mem_pkg::pline_t);
    localparam int OFF_W   = `FETCH_PAGE_OFF_W - `FETCH_LINE_OFF_W;
    localparam int IDX_W   = $clog2(`FETCH_CACHE_SETS);
    localparam int TAG_W   = PLINE_W - IDX_W;
    localparam int CRED_W  = $clog2(`FETCH_FILL_CREDITS + 1);

    // bit 0 picks the bank, so the set index starts at bit 1
    function automatic logic [IDX_W-1:0] line_index(fetch_mem_pkg::pline_t pl);
        return pl[IDX_W:1];
    endfunction

    function automatic logic [TAG_W-1:0] line_tag(fetch_mem_pkg::pline_t pl);
        return {pl[PLINE_W-1:IDX_W+1], pl[0]};
    endfunction

    fetch_mem_pkg::line_t           data_q [`FETCH_CACHE_SETS];
    logic [TAG_W-1:0]               tag_q  [`FETCH_CACHE_SETS];
    logic [`FETCH_CACHE_SETS-1:0]   valid_q;
    fetch_mem_pkg::bank_state_e     state_q;
    fetch_mem_pkg::bank_state_e     state_d;
    logic [CRED_W-1:0]              credit_q;
    fetch_mem_pkg::pline_t          req_line_q;
    fetch_mem_pkg::pline_t          cur_line;
    logic [IDX_W-1:0]               cur_idx;
    logic                           hit;
    logic                           exc;
    logic                           miss;
    logic                           send;
    logic                           rsp_accept;

    //////////////////////////////
    // lookup
    //////////////////////////////

    assign cur_line = {ppn_i, fetch_line_i[OFF_W-1:0]};   // frame + line within page
    assign cur_idx  = line_index(cur_line);
    assign hit      = valid_q[cur_idx] && (tag_q[cur_idx] == line_tag(cur_line));
    assign exc      = tlb_miss_i || prot_fault_i;

    assign miss       = active_i && !exc && !hit && (state_q == fetch_mem_pkg::ST_IDLE);
    assign send       = (state_q == fetch_mem_pkg::ST_REQ) && (credit_q != '0);
    assign rsp_accept = (state_q == fetch_mem_pkg::ST_WAIT) && fill_rsp_i.valid;

    //////////////////////////////
    // miss handling
    //////////////////////////////

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            fetch_mem_pkg::ST_IDLE: if (miss)       state_d = fetch_mem_pkg::ST_REQ;
            fetch_mem_pkg::ST_REQ:  if (send)       state_d = fetch_mem_pkg::ST_WAIT;
            fetch_mem_pkg::ST_WAIT: if (rsp_accept) state_d = fetch_mem_pkg::ST_IDLE;
            default:                                state_d = fetch_mem_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= fetch_mem_pkg::ST_IDLE;
            credit_q <= CRED_W'(`FETCH_FILL_CREDITS);
        end else begin
            state_q  <= state_d;
            credit_q <= credit_q - CRED_W'(send) + CRED_W'(fill_credit_i);
        end
    end

    // line under fill, kept even if the pointer is redirected meanwhile
    always_ff @(posedge clk_i) begin
        if (miss) begin
            req_line_q <= cur_line;
        end
    end

    // fill write, valid bits only need clearing
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (rsp_accept) begin
            valid_q[line_index(fill_rsp_i.pline)] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_accept) begin
            data_q[line_index(fill_rsp_i.pline)] <= fill_rsp_i.data;
            tag_q[line_index(fill_rsp_i.pline)]  <= line_tag(fill_rsp_i.pline);
        end
    end

    //////////////////////////////
    // outputs
    //////////////////////////////

    always_comb begin
        fetch_o.valid      = active_i && (state_q == fetch_mem_pkg::ST_IDLE) && (exc || hit);
        fetch_o.vline      = fetch_line_i;
        fetch_o.data       = exc ? '0 : data_q[cur_idx];
        fetch_o.tlb_miss   = tlb_miss_i;
        fetch_o.prot_fault = prot_fault_i;
    end

    assign fill_req_o = '{valid: send, pline: req_line_q};
    assign consumed_o = take_i && fetch_o.valid;

    a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_q <= CRED_W'(`FETCH_FILL_CREDITS));

    // the environment answers only an outstanding request
    a_rsp_in_wait: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fill_rsp_i.valid |-> (state_q == fetch_mem_pkg::ST_WAIT));

    // a fill is only asked for a line the bank lacks
    a_req_absent: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        fill_req_o.valid |-> !(valid_q[line_index(req_line_q)]
                               && (tag_q[line_index(req_line_q)] == line_tag(req_line_q))));

endmodule

`default_nettype wire

//--- hdl/fetch_tlb.sv
`default_nettype none
`include "fetch_defines.svh"

module fetch_tlb (
    input  wire logic                       clk_i,
    input  wire logic                       rst_n_i,
    input  wire fetch_mem_pkg::tlb_load_t   tlb_load_i,
    input  wire fetch_addr_pkg::vline_t     lookup_line_i,
    output fetch_mem_pkg::ppn_t             ppn_o,
    output logic                            miss_o,
    output logic                            prot_fault_o
);

    // lines per page, as address bits
    localparam int OFF_W   = `FETCH_PAGE_OFF_W - `FETCH_LINE_OFF_W;
    localparam int VLINE_W = $bits(fetch_addr_pkg::vline_t);

    fetch_mem_pkg::tlb_entry_t      entries_q [`FETCH_TLB_ENTRIES];
    logic [`FETCH_TLB_ENTRIES-1:0]  valid_q;
    logic [`FETCH_TLB_ENTRIES-1:0]  hit_vec;
    fetch_addr_pkg::vpn_t           lookup_vpn;
    fetch_mem_pkg::ppn_t            ppn_sel;
    logic                           exec_sel;

    assign lookup_vpn = lookup_line_i[VLINE_W-1:OFF_W];

    //////////////////////////////
    // entry storage
    //////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (tlb_load_i.en) begin
            valid_q[tlb_load_i.idx] <= tlb_load_i.entry.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (tlb_load_i.en) begin
            entries_q[tlb_load_i.idx] <= tlb_load_i.entry;
        end
    end

    // associative match, at most one entry hits so OR-ing is safe
    always_comb begin
        hit_vec  = '0;
        ppn_sel  = '0;
        exec_sel = 1'b0;
        for (int i = 0; i < `FETCH_TLB_ENTRIES; i++) begin
            hit_vec[i] = valid_q[i] && entries_q[i].present
                      && (entries_q[i].vpn == lookup_vpn);
            if (hit_vec[i]) begin
                ppn_sel  = ppn_sel | entries_q[i].ppn;
                exec_sel = exec_sel | entries_q[i].executable;
            end
        end
    end

    assign ppn_o        = ppn_sel;
    assign miss_o       = ~|hit_vec;
    assign prot_fault_o = (|hit_vec) & ~exec_sel;   // mapped but no execute right

    a_single_hit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(hit_vec));

endmodule

`default_nettype wire

//--- hdl/fetch_addr_select.sv
`default_nettype none
`include "fetch_defines.svh"

module fetch_addr_select #(
    parameter int PARITY = 0
) (
    input  wire logic                       clk_i,
    input  wire logic                       rst_n_i,
    input  wire fetch_addr_pkg::redirect_t  redirect_i,
    input  wire logic                       consumed_i,
    output fetch_addr_pkg::vline_t          fetch_line_o,
    output logic                            started_o
);

    fetch_addr_pkg::vline_t        init_line;
    fetch_addr_pkg::vline_t        init_line_par;
    fetch_addr_pkg::vline_t        ptr_q;
    fetch_addr_pkg::vline_t        ptr_d;
    fetch_addr_pkg::redirect_src_e src_sel;
    logic                          started_q;

    // init line of our parity, next line if the init line is the other bank's
    assign init_line = redirect_i.init_addr[`FETCH_VADDR_W-1:`FETCH_LINE_OFF_W];
    assign init_line_par = (init_line[0] == 1'(PARITY))
                         ? init_line
                         : init_line + fetch_addr_pkg::vline_t'(1);

    //////////////////////////////
    // source priority
    //////////////////////////////

    always_comb begin
        if (redirect_i.init_valid) begin
            src_sel = fetch_addr_pkg::SRC_INIT;
        end else if (redirect_i.resteer_valid) begin
            src_sel = fetch_addr_pkg::SRC_RESTEER;
        end else if (redirect_i.bp_valid) begin
            src_sel = fetch_addr_pkg::SRC_BP;
        end else begin
            src_sel = fetch_addr_pkg::SRC_SEQ;
        end
    end

    always_comb begin
        unique case (src_sel)
            fetch_addr_pkg::SRC_INIT:    ptr_d = init_line_par;
            fetch_addr_pkg::SRC_RESTEER: ptr_d = (PARITY == 1) ? redirect_i.resteer_odd
                                                               : redirect_i.resteer_even;
            fetch_addr_pkg::SRC_BP:      ptr_d = (PARITY == 1) ? redirect_i.bp_odd
                                                               : redirect_i.bp_even;
            default:                     ptr_d = consumed_i ? ptr_q + fetch_addr_pkg::vline_t'(2)
                                                            : ptr_q;   // other bank owns the gap
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ptr_q     <= '0;
            started_q <= 1'b0;
        end else begin
            ptr_q <= ptr_d;
            if (src_sel != fetch_addr_pkg::SRC_SEQ) begin
                started_q <= 1'b1;
            end
        end
    end

    assign fetch_line_o = ptr_q;
    assign started_o    = started_q;

    // a redirected pointer has to land in this bank
    a_ptr_parity: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (src_sel != fetch_addr_pkg::SRC_SEQ) |=> (ptr_q[0] == 1'(PARITY)));

endmodule

`default_nettype wire

//--- hdl/fetch_mem_pkg.sv
`default_nettype none
`include "fetch_defines.svh"

package fetch_mem_pkg;

    typedef logic [`FETCH_PADDR_W-`FETCH_LINE_OFF_W-1:0] pline_t;    // physical line address
    typedef logic [`FETCH_PADDR_W-`FETCH_PAGE_OFF_W-1:0] ppn_t;      // physical frame
    typedef logic [`FETCH_LINE_W-1:0] line_t;

    //////////////////////////////
    // translation
    //////////////////////////////

    typedef struct packed {
        logic                 valid;
        logic                 present;
        logic                 executable;   // clear means fetch faults
        fetch_addr_pkg::vpn_t vpn;
        ppn_t                 ppn;
    } tlb_entry_t;

    typedef struct packed {
        logic                                  en;
        logic [$clog2(`FETCH_TLB_ENTRIES)-1:0] idx;
        tlb_entry_t                            entry;
    } tlb_load_t;

    //////////////////////////////
    // fill channel
    //////////////////////////////

    typedef struct packed {
        logic   valid;
        pline_t pline;
    } fill_req_t;

    typedef struct packed {
        logic   valid;
        pline_t pline;
        line_t  data;
    } fill_rsp_t;

    // what a bank presents to the decoder
    typedef struct packed {
        logic                   valid;
        fetch_addr_pkg::vline_t vline;
        line_t                  data;         // zero on an exception
        logic                   tlb_miss;
        logic                   prot_fault;
    } fetch_out_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } bank_state_e;

endpackage

`default_nettype wire

//--- hdl/fetch_addr_pkg.sv
`default_nettype none
`include "fetch_defines.svh"

package fetch_addr_pkg;

    //////////////////////////////
    // address types
    //////////////////////////////

    typedef logic [`FETCH_VADDR_W-1:0] vaddr_t;                      // byte address
    typedef logic [`FETCH_VADDR_W-`FETCH_LINE_OFF_W-1:0] vline_t;    // 16-byte line address
    typedef logic [`FETCH_VADDR_W-`FETCH_PAGE_OFF_W-1:0] vpn_t;      // virtual page number

    //////////////////////////////
    // control flow redirects
    //////////////////////////////

    typedef struct packed {
        logic   init_valid;
        vaddr_t init_addr;     // byte address, banks derive their own line
        logic   resteer_valid;
        vline_t resteer_even;
        vline_t resteer_odd;
        logic   bp_valid;      // taken branch from the predictor
        vline_t bp_even;
        vline_t bp_odd;
    } redirect_t;

    // winning pointer source, seq means no redirect this cycle
    typedef enum logic [1:0] {
        SRC_SEQ,
        SRC_BP,
        SRC_RESTEER,
        SRC_INIT
    } redirect_src_e;

endpackage

`default_nettype wire

//--- hdl/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// address widths, in bits
`define FETCH_VADDR_W 32
`define FETCH_PADDR_W 20

// a line is 16 bytes, a page 4 KB
`define FETCH_LINE_OFF_W 4
`define FETCH_PAGE_OFF_W 12

// line data width
`define FETCH_LINE_W 128

// translation
`define FETCH_TLB_ENTRIES 8

// cache geometry, per bank
`define FETCH_CACHE_SETS 16

// fill channel credits each bank holds out of reset
`define FETCH_FILL_CREDITS 2

`endif
